// ==== harness_top.f ====
hdl/soc_bus_pkg.sv
hdl/soc_map_pkg.sv
hdl/debug_req_gate.sv
hdl/main_mem.sv
hdl/boot_rom.sv
hdl/bus_fabric.sv
hdl/harness_top.sv
tests/harness_properties.sv
tests/harness_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it; exits nonzero when the run fails
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module harness_tb \
  -f harness_top.f \
  -o harness_sim

./obj_dir/harness_sim | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  echo "run.sh: simulation reported failure"
  exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
  echo "run.sh: simulation ended without a result"
  exit 1
fi
echo "run.sh: done"

// ==== tests/harness_tb.sv ====
// Runs with MEM_WORDS 1024 and a 20-cycle debug delay; memory reads only hit words written first
`timescale 1ns/10ps

module harness_tb;

  localparam int unsigned MEM_WORDS   = 1024;
  localparam int unsigned DEBUG_DELAY = 20;
  localparam int unsigned MEM_IDX_W   = $clog2(MEM_WORDS);
  localparam int unsigned ROM_IDX_W   = $clog2(soc_map_pkg::ROM_IMAGE_WORDS);
  localparam int unsigned SLOTS       = 32;
  localparam int unsigned SLOT_STRIDE = (MEM_WORDS - 1) / (SLOTS - 1);

  typedef struct packed {
    logic               ack;
    logic               err;
    logic               check_dat;
    soc_bus_pkg::data_t dat;
  } expect_t;

  logic                 clk_i;
  logic                 rst_ni;
  soc_bus_pkg::wb_req_t bus_req;
  soc_bus_pkg::wb_rsp_t bus_rsp;
  logic                 debug_req;
  logic                 debug_en;
  logic                 debug_out;

  soc_bus_pkg::data_t   shadow [MEM_WORDS];
  expect_t              expected_q [$];
  logic [31:0]          lcg_state = 32'hf721;
  int unsigned          accesses  = 0;

  harness_top #(
    .MEM_WORDS          ( MEM_WORDS   ),
    .DEBUG_DELAY_CYCLES ( DEBUG_DELAY )
  ) harness_top_inst (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .bus_req_i   ( bus_req   ),
    .bus_rsp_o   ( bus_rsp   ),
    .debug_req_i ( debug_req ),
    .debug_en_i  ( debug_en  ),
    .debug_req_o ( debug_out )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // Helpers and reference model
  // ----------------------------------------
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                         $time, name, actual, expected));
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Slots spread from word 0 to the last word
  function automatic soc_bus_pkg::addr_t slot_addr(input int unsigned slot);
    return soc_map_pkg::MEM_BASE + soc_bus_pkg::addr_t'(slot * SLOT_STRIDE * 8);
  endfunction

  function automatic expect_t ref_model(input soc_bus_pkg::wb_req_t req);
    expect_t              rsp;
    soc_bus_pkg::addr_t   offset;
    logic [MEM_IDX_W-1:0] idx;
    rsp           = '0;
    rsp.err       = 1'b1;
    rsp.check_dat = 1'b1;
    if (req.adr >= soc_map_pkg::ROM_BASE && !req.we &&
        req.adr < soc_map_pkg::ROM_BASE + soc_map_pkg::ROM_LENGTH) begin
      offset  = (req.adr - soc_map_pkg::ROM_BASE) >> 3;
      rsp.err = 1'b0;
      rsp.ack = 1'b1;
      if (offset < soc_bus_pkg::addr_t'(soc_map_pkg::ROM_IMAGE_WORDS)) begin
        rsp.dat = soc_map_pkg::BOOT_IMAGE[offset[ROM_IDX_W-1:0]];
      end
    end else if (req.adr >= soc_map_pkg::MEM_BASE &&
                 req.adr < soc_map_pkg::MEM_BASE + soc_bus_pkg::addr_t'(8 * MEM_WORDS)) begin
      offset  = (req.adr - soc_map_pkg::MEM_BASE) >> 3;
      idx     = offset[MEM_IDX_W-1:0];
      rsp.err = 1'b0;
      rsp.ack = 1'b1;
      if (req.we) begin
        rsp.check_dat = 1'b0;
        for (int lane = 0; lane < 8; lane++) begin
          if (req.sel[lane]) begin
            shadow[idx][8*lane +: 8] = req.dat[8*lane +: 8];
          end
        end
      end else begin
        rsp.dat = shadow[idx];
      end
    end
    return rsp;
  endfunction

  // One access, response expected on the first edge
  task automatic bus_access(input logic we, input soc_bus_pkg::addr_t adr,
                            input soc_bus_pkg::data_t dat, input soc_bus_pkg::sel_t sel);
    soc_bus_pkg::wb_req_t req;
    int unsigned          waited;
    req     = '0;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = adr;
    req.dat = dat;
    req.sel = sel;
    expected_q.push_back(ref_model(req));
    accesses++;
    @(posedge clk_i);
    bus_req <= req;
    @(negedge clk_i);
    check_value("bus_rsp_o ack or err before the first edge",
                64'(bus_rsp.ack | bus_rsp.err), 64'd0);
    waited = 0;
    while (!(bus_rsp.ack || bus_rsp.err) && waited < 8) begin
      @(negedge clk_i);
      waited++;
    end
    if (!(bus_rsp.ack || bus_rsp.err)) begin
      fail_run($sformatf("no bus response within 8 cycles for address %h", adr));
    end else begin
      check_value("bus response latency in cycles", 64'(waited), 64'd1);
    end
    @(posedge clk_i);
    bus_req <= '0;
  endtask

  task automatic expect_debug(input logic level, input string what);
    int unsigned n;
    @(negedge clk_i);
    n = 0;
    while (debug_out !== level && n < 2) begin
      @(negedge clk_i);
      n++;
    end
    if (debug_out !== level) begin
      fail_run(what);
    end
  endtask

  // ----------------------------------------
  // Response compare and watchdog
  // ----------------------------------------
  initial begin : compare_responses
    expect_t exp_rsp;
    forever begin
      @(negedge clk_i);
      if (rst_ni && (bus_rsp.ack || bus_rsp.err)) begin
        if (expected_q.size() == 0) begin
          fail_run("bus response seen with no access pending");
        end else begin
          exp_rsp = expected_q.pop_front();
          check_value("bus_rsp_o.ack", 64'(bus_rsp.ack), 64'(exp_rsp.ack));
          check_value("bus_rsp_o.err", 64'(bus_rsp.err), 64'(exp_rsp.err));
          if (exp_rsp.check_dat) begin
            check_value("bus_rsp_o.dat", bus_rsp.dat, exp_rsp.dat);
          end
        end
      end
    end
  end

  initial begin : watchdog
    int unsigned cycles;
    cycles = 0;
    forever begin
      @(posedge clk_i);
      cycles++;
      if (cycles > 200 + 4 * accesses) begin
        fail_run($sformatf("timeout after %0d cycles with %0d accesses issued",
                           cycles, accesses));
      end
    end
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin : run_tests
    int unsigned rise;
    rst_ni    = 1'b0;
    bus_req   = '0;
    debug_req = 1'b1;
    debug_en  = 1'b1;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_value("bus_rsp_o.ack", 64'(bus_rsp.ack), 64'd0);
    check_value("bus_rsp_o.err", 64'(bus_rsp.err), 64'd0);
    check_value("debug_req_o", 64'(debug_out), 64'd0);

    // Debug request held off, then gated by enable and request
    rise = 0;
    while (!debug_out && rise < 40) begin
      @(negedge clk_i);
      rise++;
    end
    if (rise < DEBUG_DELAY - 1 || rise > DEBUG_DELAY + 2) begin
      fail_run($sformatf("debug_req_o rose %0d cycles after reset, outside %0d to %0d",
                         rise, DEBUG_DELAY - 1, DEBUG_DELAY + 2));
    end
    @(posedge clk_i);
    debug_en <= 1'b0;
    expect_debug(1'b0, "debug_req_o did not fall after debug_en_i went low");
    repeat (3) begin
      @(negedge clk_i);
      check_value("debug_req_o", 64'(debug_out), 64'd0);
    end
    @(posedge clk_i);
    debug_en <= 1'b1;
    expect_debug(1'b1, "debug_req_o did not rise after debug_en_i went high");
    @(posedge clk_i);
    debug_req <= 1'b0;
    expect_debug(1'b0, "debug_req_o did not follow debug_req_i low");
    @(posedge clk_i);
    debug_req <= 1'b1;
    expect_debug(1'b1, "debug_req_o did not follow debug_req_i high");

    // Boot image, then zero past its end
    for (int i = 0; i < 32; i++) begin
      bus_access(1'b0, soc_map_pkg::ROM_BASE + soc_bus_pkg::addr_t'(8 * i), '0, '1);
    end

    // Full-word fill first, so no read sees an unwritten byte
    for (int unsigned s = 0; s < SLOTS; s++) begin
      bus_access(1'b1, slot_addr(s), {lcg_next(), lcg_next()}, '1);
    end
    for (int n = 0; n < 200; n++) begin
      bus_access(1'b1, slot_addr((lcg_next() >> 16) % SLOTS), {lcg_next(), lcg_next()},
                 soc_bus_pkg::sel_t'(lcg_next() >> 24));
      if ((lcg_next() >> 30) != 0) begin
        bus_access(1'b0, slot_addr((lcg_next() >> 16) % SLOTS), '0,
                   soc_bus_pkg::sel_t'(lcg_next() >> 24));
      end
    end

    // Error responses; the write past the window would alias to word 0
    bus_access(1'b0, 32'h4000_0000, '0, '1);
    bus_access(1'b1, 32'h4000_0000, {lcg_next(), lcg_next()}, '1);
    bus_access(1'b1, soc_map_pkg::MEM_BASE + soc_bus_pkg::addr_t'(8 * MEM_WORDS),
               {lcg_next(), lcg_next()}, '1);
    bus_access(1'b0, soc_map_pkg::MEM_BASE + soc_bus_pkg::addr_t'(8 * MEM_WORDS), '0, '1);
    bus_access(1'b1, soc_map_pkg::MEM_BASE - 32'd8, {lcg_next(), lcg_next()}, '1);
    bus_access(1'b1, soc_map_pkg::ROM_BASE + 32'd8, {lcg_next(), lcg_next()}, '1);
    bus_access(1'b0, soc_map_pkg::ROM_BASE + 32'd8, '0, '1);
    for (int unsigned s = 0; s < SLOTS; s++) begin
      bus_access(1'b0, slot_addr(s), '0, '1);
    end

    check_value("accesses left without response", 64'(expected_q.size()), 64'd0);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== tests/harness_properties.sv ====
// Bound to harness_top; the delay window is counted from reset release with the DUT's own parameter
`timescale 1ns/10ps

module harness_properties #(
  parameter int unsigned DEBUG_DELAY_CYCLES = 500
) (
  input logic                 clk_i,
  input logic                 rst_ni,
  input soc_bus_pkg::wb_req_t bus_req_i,
  input soc_bus_pkg::wb_rsp_t bus_rsp_i,
  input logic                 gated_debug_i
);

  int unsigned cycles_q;

  // Edges since reset, saturating at the delay
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycles_q <= 0;
    end else if (cycles_q < DEBUG_DELAY_CYCLES) begin
      cycles_q <= cycles_q + 1;
    end
  end

  // ----------------------------------------
  // Bus handshake
  // ----------------------------------------
  ack_err_exclusive: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(bus_rsp_i.ack && bus_rsp_i.err)
  ) else $error("ack and err are high together");

  rsp_after_request: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (bus_rsp_i.ack || bus_rsp_i.err) |-> $past(bus_req_i.cyc && bus_req_i.stb)
  ) else $error("response without a preceding cyc and stb");

  rsp_single_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (bus_rsp_i.ack || bus_rsp_i.err) |=> !(bus_rsp_i.ack || bus_rsp_i.err)
  ) else $error("response held longer than one cycle");

  // Debug hold-off after reset
  debug_held_off: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (cycles_q < DEBUG_DELAY_CYCLES) |-> !gated_debug_i
  ) else $error("debug_req_o high inside the post-reset delay");

endmodule

bind harness_top harness_properties #(
  .DEBUG_DELAY_CYCLES ( DEBUG_DELAY_CYCLES )
) harness_properties_inst (
  .clk_i         ( clk_i       ),
  .rst_ni        ( rst_ni      ),
  .bus_req_i     ( bus_req_i   ),
  .bus_rsp_i     ( bus_rsp_o   ),
  .gated_debug_i ( debug_req_o )
);

// ==== hdl/harness_top.sv ====
// One Wishbone classic master, one access in flight, each access answered after one wait state
`timescale 1ns/10ps

module harness_top #(
  parameter int unsigned MEM_WORDS          = 1024,
  parameter int unsigned DEBUG_DELAY_CYCLES = 500
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  soc_bus_pkg::wb_req_t bus_req_i,
  output soc_bus_pkg::wb_rsp_t bus_rsp_o,
  input  logic                 debug_req_i,
  input  logic                 debug_en_i,
  output logic                 debug_req_o
);

  soc_bus_pkg::wb_req_t rom_req;
  soc_bus_pkg::wb_rsp_t rom_rsp;
  soc_bus_pkg::wb_req_t mem_req;
  soc_bus_pkg::wb_rsp_t mem_rsp;

  // ----------------------------------------
  // Fabric
  // ----------------------------------------
  bus_fabric #(
    .MEM_WORDS ( MEM_WORDS )
  ) bus_fabric_inst (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .bus_req_i ( bus_req_i ),
    .bus_rsp_o ( bus_rsp_o ),
    .rom_req_o ( rom_req   ),
    .rom_rsp_i ( rom_rsp   ),
    .mem_req_o ( mem_req   ),
    .mem_rsp_i ( mem_rsp   )
  );

  // ----------------------------------------
  // Slaves
  // ----------------------------------------
  boot_rom boot_rom_inst (
    .clk_i  ( clk_i   ),
    .rst_ni ( rst_ni  ),
    .req_i  ( rom_req ),
    .rsp_o  ( rom_rsp )
  );

  main_mem #(
    .MEM_WORDS ( MEM_WORDS )
  ) main_mem_inst (
    .clk_i  ( clk_i   ),
    .rst_ni ( rst_ni  ),
    .req_i  ( mem_req ),
    .rsp_o  ( mem_rsp )
  );

  // ----------------------------------------
  // Debug request
  // ----------------------------------------
  debug_req_gate #(
    .DEBUG_DELAY_CYCLES ( DEBUG_DELAY_CYCLES )
  ) debug_req_gate_inst (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// ==== hdl/bus_fabric.sv ====
// Single master, single access in flight; unmapped accesses and ROM writes end in err
`timescale 1ns/10ps

module bus_fabric #(
  parameter int unsigned MEM_WORDS = 1024
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  soc_bus_pkg::wb_req_t bus_req_i,
  output soc_bus_pkg::wb_rsp_t bus_rsp_o,
  output soc_bus_pkg::wb_req_t rom_req_o,
  input  soc_bus_pkg::wb_rsp_t rom_rsp_i,
  output soc_bus_pkg::wb_req_t mem_req_o,
  input  soc_bus_pkg::wb_rsp_t mem_rsp_i
);

  localparam soc_bus_pkg::addr_t MEM_LENGTH = soc_bus_pkg::addr_t'(MEM_WORDS * 8);

  soc_bus_pkg::addr_t       rom_off;
  soc_bus_pkg::addr_t       mem_off;
  soc_map_pkg::region_e     region;
  soc_map_pkg::region_e     target;
  soc_map_pkg::region_e     target_q;
  soc_map_pkg::word_index_t word_idx;
  logic                     access;
  logic                     err_q;

  // ----------------------------------------
  // Address decode
  // ----------------------------------------

  // Offsets wrap to large values below each base
  assign rom_off = bus_req_i.adr - soc_map_pkg::ROM_BASE;
  assign mem_off = bus_req_i.adr - soc_map_pkg::MEM_BASE;

  always_comb begin
    if (rom_off < soc_map_pkg::ROM_LENGTH) begin
      region   = soc_map_pkg::REGION_ROM;
      word_idx = soc_map_pkg::word_index_t'(rom_off >> 3);
    end else if (mem_off < MEM_LENGTH) begin
      region   = soc_map_pkg::REGION_MEM;
      word_idx = soc_map_pkg::word_index_t'(mem_off >> 3);
    end else begin
      region   = soc_map_pkg::REGION_NONE;
      word_idx = '0;
    end
  end

  // ROM writes are refused like unmapped addresses
  assign target = (region == soc_map_pkg::REGION_ROM && bus_req_i.we) ?
                  soc_map_pkg::REGION_NONE : region;
  assign access = bus_req_i.cyc & bus_req_i.stb;

  always_comb begin
    rom_req_o     = bus_req_i;
    rom_req_o.adr = soc_bus_pkg::addr_t'(word_idx);
    rom_req_o.stb = access & (target == soc_map_pkg::REGION_ROM);
    mem_req_o     = bus_req_i;
    mem_req_o.adr = soc_bus_pkg::addr_t'(word_idx);
    mem_req_o.stb = access & (target == soc_map_pkg::REGION_MEM);
  end

  // ----------------------------------------
  // Error response and in-flight target
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q    <= 1'b0;
      target_q <= soc_map_pkg::REGION_NONE;
    end else begin
      err_q <= access & (target == soc_map_pkg::REGION_NONE) & ~err_q;
      if (access) begin
        target_q <= target;
      end
    end
  end

  // Response merge
  always_comb begin
    case (target_q)
      soc_map_pkg::REGION_ROM: bus_rsp_o = rom_rsp_i;
      soc_map_pkg::REGION_MEM: bus_rsp_o = mem_rsp_i;
      default:                 bus_rsp_o = '0;
    endcase
    bus_rsp_o.err = bus_rsp_o.err | err_q;
  end

endmodule

// ==== hdl/boot_rom.sv ====
// Read-only image of ROM_IMAGE_WORDS words; adr is a word index, writes are not expected
`timescale 1ns/10ps

module boot_rom (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  soc_bus_pkg::wb_req_t req_i,
  output soc_bus_pkg::wb_rsp_t rsp_o
);

  localparam int unsigned IDX_W = $clog2(soc_map_pkg::ROM_IMAGE_WORDS);

  logic               access;
  logic               in_image;
  logic               ack_q;
  soc_bus_pkg::data_t rdata;
  soc_bus_pkg::data_t dat_q;

  assign access   = req_i.cyc & req_i.stb & ~ack_q;
  assign in_image = req_i.adr < soc_bus_pkg::addr_t'(soc_map_pkg::ROM_IMAGE_WORDS);

  // Past the image reads as zero
  always_comb begin
    if (in_image) begin
      rdata = soc_map_pkg::BOOT_IMAGE[req_i.adr[IDX_W-1:0]];
    end else begin
      rdata = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      dat_q <= rdata;
    end
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.err = 1'b0;
  assign rsp_o.dat = dat_q;

endmodule

// ==== hdl/main_mem.sv ====
// MEM_WORDS x 64-bit memory; adr is a word index within range, contents undefined until written
`timescale 1ns/10ps

module main_mem #(
  parameter int unsigned MEM_WORDS = 1024
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  soc_bus_pkg::wb_req_t req_i,
  output soc_bus_pkg::wb_rsp_t rsp_o
);

  localparam int unsigned IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  soc_bus_pkg::data_t mem_q [MEM_WORDS];
  soc_bus_pkg::data_t dat_q;
  logic [IDX_W-1:0]   idx;
  logic               access;
  logic               ack_q;

  assign idx    = req_i.adr[IDX_W-1:0];
  assign access = req_i.cyc & req_i.stb & ~ack_q;

  // ----------------------------------------
  // Handshake
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // ----------------------------------------
  // Storage
  // ----------------------------------------

  // Write lands on the ack edge, only selected lanes
  always_ff @(posedge clk_i) begin
    if (access && req_i.we) begin
      for (int lane = 0; lane < int'(soc_bus_pkg::SEL_WIDTH); lane++) begin
        if (req_i.sel[lane]) begin
          mem_q[idx][8*lane +: 8] <= req_i.dat[8*lane +: 8];
        end
      end
    end
  end

  // Whole word returned, sel ignored on reads
  always_ff @(posedge clk_i) begin
    if (access && !req_i.we) begin
      dat_q <= mem_q[idx];
    end
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.err = 1'b0;
  assign rsp_o.dat = dat_q;

endmodule

// ==== hdl/debug_req_gate.sv ====
// Debug request held off for DEBUG_DELAY_CYCLES after reset (one cycle late), blocked when disabled
`timescale 1ns/10ps

module debug_req_gate #(
  parameter int unsigned DEBUG_DELAY_CYCLES = 500
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_en_i,
  output logic debug_req_o
);

  localparam int unsigned CNT_W =
    (DEBUG_DELAY_CYCLES > 0) ? $clog2(DEBUG_DELAY_CYCLES + 1) : 1;

  logic [CNT_W-1:0] cnt_d;
  logic [CNT_W-1:0] cnt_q;
  logic             req_q;

  // Stops at zero
  assign cnt_d = (cnt_q != '0) ? cnt_q - 1'b1 : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CNT_W'(DEBUG_DELAY_CYCLES);
      req_q <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      req_q <= (cnt_q == '0) & debug_en_i & debug_req_i;
    end
  end

  assign debug_req_o = req_q;

endmodule

// ==== hdl/soc_map_pkg.sv ====
// Fixed memory map; the memory window length comes from MEM_WORDS, the boot image is 16 words
package soc_map_pkg;

  // Decode targets of the fabric
  typedef enum logic [1:0] {
    REGION_ROM,
    REGION_MEM,
    REGION_NONE
  } region_e;

  // Word index inside one region
  typedef logic [23:0] word_index_t;

  localparam soc_bus_pkg::addr_t ROM_BASE   = 32'h0001_0000;
  localparam soc_bus_pkg::addr_t ROM_LENGTH = 32'h0001_0000;
  localparam soc_bus_pkg::addr_t MEM_BASE   = 32'h8000_0000;

  localparam int unsigned ROM_IMAGE_WORDS = 16;

  // Boot image, two instructions per word
  localparam soc_bus_pkg::data_t BOOT_IMAGE [ROM_IMAGE_WORDS] = '{
    64'h0000_0297_f140_2573,
    64'h0182_b283_0202_8593,
    64'h0002_8067_0000_0013,
    64'h8000_0537_0010_0593,
    64'h00b5_3023_0005_3603,
    64'h0006_0463_ffdf_f06f,
    64'h1050_0073_0000_0013,
    64'hdead_beef_cafe_f00d,
    64'h0123_4567_89ab_cdef,
    64'hfedc_ba98_7654_3210,
    64'h5a5a_5a5a_a5a5_a5a5,
    64'h0000_0000_ffff_ffff,
    64'h1111_2222_3333_4444,
    64'h8000_0000_0000_0001,
    64'h0bad_c0de_0000_7777,
    64'h0000_0000_0000_0073
  };

endpackage

// ==== hdl/soc_bus_pkg.sv ====
// Wishbone classic types for one 64-bit master; no burst, tag or cycle-type fields
package soc_bus_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 64;
  localparam int unsigned SEL_WIDTH  = DATA_WIDTH / 8;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [SEL_WIDTH-1:0]  sel_t;

  // ----------------------------------------
  // Wishbone channels
  // ----------------------------------------

  // Master to slave, held stable until ack or err
  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    data_t dat;
    sel_t  sel;
  } wb_req_t;

  // Slave to master, ack and err last one cycle
  typedef struct packed {
    logic  ack;
    logic  err;
    data_t dat;
  } wb_rsp_t;

endpackage
